//--- src.f
hdl/isa_pkg.sv
hdl/mem_map_pkg.sv
hdl/fetch_stage.sv
hdl/operand_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/micro16_top.sv
verification/micro16_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the micro16 testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module micro16_tb -o micro16_sim
./obj_dir/micro16_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

//--- verification/micro16_tb.sv
/* Directed testbench for micro16_top. The bus slave decodes only the low 8 address
   bits, and each program holds at most 31 words before the HALT that is appended */
`timescale 1ns/1ps

module micro16_tb;

    localparam int CORE_ID        = 3;
    localparam int MAX_WAIT       = 3;
    localparam int SLOW_WAIT      = 2;
    localparam int MAX_PROG       = 32;
    localparam int NUM_TESTS      = 6;
    // Six base cycles plus a bus access with every wait state
    localparam int INSTR_CYCLES   = 6 + 2 + MAX_WAIT + SLOW_WAIT;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (MAX_PROG * (INSTR_CYCLES + 1) + 8);

    logic               clk = 1'b0;
    logic               reset;
    logic               prog_we;
    logic [5:0]         prog_addr;
    isa_pkg::instr_t    prog_data;
    mem_map_pkg::data_t prdata = '0;
    logic               pready = 1'b0;
    logic [5:0]         pc;
    logic               halted;
    mem_map_pkg::data_t paddr;
    logic               pwrite;
    logic               psel;
    logic               penable;
    mem_map_pkg::data_t pwdata;

    // Bus slave state
    mem_map_pkg::data_t bus_mem [256];
    mem_map_pkg::data_t wr_addr_q [$];
    mem_map_pkg::data_t wr_data_q [$];
    int                 read_count = 0;
    int                 wait_left = 0;
    int                 extra_wait;

    logic [15:0]        program_q [$];
    mem_map_pkg::data_t exp_addr_q [$];
    mem_map_pkg::data_t exp_data_q [$];
    int                 first_write;
    int                 first_read;
    int                 check_count = 0;
    int                 error_count = 0;
    int                 cycle_count = 0;

    micro16_top #(
        .INSTR_DEPTH(64),
        .CORE_ID(CORE_ID)
    ) u_micro16_top (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the core did not halt (%0d errors so far)",
                     cycle_count, error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Latest write to an address wins over the preloaded contents
    function automatic mem_map_pkg::data_t bus_lookup(input mem_map_pkg::data_t addr);
        for (int i = wr_addr_q.size() - 1; i >= 0; i--) begin
            if (wr_addr_q[i] == addr) begin
                return wr_data_q[i];
            end
        end
        return bus_mem[addr[7:0]];
    endfunction

    always @(posedge clk) begin
        if (psel && penable && pready) begin
            pready <= 1'b0;
            if (pwrite) begin
                wr_addr_q.push_back(paddr);
                wr_data_q.push_back(pwdata);
            end else begin
                read_count <= read_count + 1;
            end
        end else if (psel) begin
            // Delay drawn in the setup phase, counted down while penable is high
            if (!penable) begin
                wait_left = int'($urandom % (MAX_WAIT + 1)) + extra_wait;
            end else begin
                wait_left = wait_left - 1;
            end
            if (wait_left == 0) begin
                pready <= 1'b1;
                prdata <= bus_lookup(paddr);
            end
        end
    end

    task automatic compare(input string name, input mem_map_pkg::data_t actual,
                           input mem_map_pkg::data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    function automatic void emit_reg(input isa_pkg::opcode_e op, input logic [2:0] rd,
                                     input logic [2:0] ra, input logic [4:0] simm5);
        program_q.push_back({op, rd, ra, simm5});
    endfunction

    function automatic void emit_imm(input isa_pkg::opcode_e op, input logic [2:0] rd,
                                     input logic [7:0] imm8);
        program_q.push_back({op, rd, imm8});
    endfunction

    function automatic void expect_write(input mem_map_pkg::data_t addr,
                                         input mem_map_pkg::data_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endfunction

    // Leaves the core in reset with the program loaded and HALT appended
    task automatic load_program();
        emit_reg(isa_pkg::OP_HALT, 3'd0, 3'd0, 5'd0);
        @(posedge clk);
        reset <= 1'b1;
        foreach (program_q[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 6'(i);
            prog_data <= program_q[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (2) @(posedge clk);
        program_q.delete();
        first_write = wr_addr_q.size();
        first_read  = read_count;
    endtask

    task automatic release_reset();
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_halted();
        do begin
            @(posedge clk);
        end while (!halted);
    endtask

    task automatic run_program();
        load_program();
        release_reset();
        wait_halted();
    endtask

    task automatic check_bus_writes();
        int n;
        n = wr_addr_q.size() - first_write;
        compare("bus write count", 16'(n), 16'(exp_addr_q.size()));
        for (int k = 0; k < exp_addr_q.size() && k < n; k++) begin
            compare("paddr", wr_addr_q[first_write + k], exp_addr_q[k]);
            compare("pwdata", wr_data_q[first_write + k], exp_data_q[k]);
        end
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic test_reset_state();
        emit_reg(isa_pkg::OP_NOP, 3'd0, 3'd0, 5'd0);
        load_program();
        for (int phase = 0; phase < 2; phase++) begin
            @(negedge clk);
            compare("psel", 16'(psel), 16'h0000);
            compare("penable", 16'(penable), 16'h0000);
            compare("halted", 16'(halted), 16'h0000);
            compare("pc", 16'(pc), 16'h0000);
            if (phase == 0) begin
                release_reset();
            end
        end
        wait_halted();
        // HALT sits right after the NOP
        compare("pc", 16'(pc), 16'h0001);
        check_bus_writes();
    endtask

    task automatic test_bus_store();
        emit_imm(isa_pkg::OP_MOVI, 3'd1, 8'h80);
        emit_imm(isa_pkg::OP_MOVI, 3'd2, 8'h5C);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd0);
        run_program();
        expect_write(16'h0080, 16'h005C);
        check_bus_writes();
    endtask

    task automatic test_alu_ops();
        mem_map_pkg::data_t x;
        mem_map_pkg::data_t y;
        logic [4:0]         sub_op [9];
        mem_map_pkg::data_t expected [9];
        x = 16'h00B6;
        y = 16'h0003;
        sub_op = '{isa_pkg::ARITH_ADD, isa_pkg::ARITH_SUB, 5'h09, isa_pkg::BIT_OR,
                   isa_pkg::BIT_XOR, isa_pkg::BIT_AND, isa_pkg::BIT_NOT, isa_pkg::BIT_SHL,
                   isa_pkg::BIT_SHR};
        // Add-immediate adds R[ra] plus the low four bits of simm5
        expected = '{x + y, x - y, x + y + 16'h0009, x | y, x ^ y, x & y, ~y, x << y, x >> y};
        emit_imm(isa_pkg::OP_MOVI, 3'd1, 8'h80);
        emit_imm(isa_pkg::OP_MOVI, 3'd2, x[7:0]);
        emit_imm(isa_pkg::OP_MOVI, 3'd3, y[7:0]);
        for (int k = 0; k < 9; k++) begin
            emit_reg(isa_pkg::OP_MOV, 3'd4, 3'd2, 5'd0);
            emit_reg((k < 3) ? isa_pkg::OP_ARITH : isa_pkg::OP_BIT, 3'd4, 3'd3, sub_op[k]);
            emit_reg(isa_pkg::OP_SW, 3'd4, 3'd1, 5'(k));
            expect_write(16'h0080 + 16'(k), expected[k]);
        end
        run_program();
        check_bus_writes();
    endtask

    task automatic test_slow_load();
        extra_wait = SLOW_WAIT;
        bus_mem[8'h90] = 16'h1234;
        emit_imm(isa_pkg::OP_MOVI, 3'd1, 8'h90);
        emit_reg(isa_pkg::OP_LW, 3'd2, 3'd1, 5'd0);
        emit_imm(isa_pkg::OP_MOVI, 3'd3, 8'h25);
        emit_reg(isa_pkg::OP_ARITH, 3'd2, 3'd3, isa_pkg::ARITH_ADD);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd1);
        // Offset -1 reaches a word that still holds the fill pattern
        emit_reg(isa_pkg::OP_LW, 3'd4, 3'd1, 5'h1F);
        emit_reg(isa_pkg::OP_SW, 3'd4, 3'd1, 5'd2);
        run_program();
        expect_write(16'h0091, 16'h1234 + 16'h0025);
        expect_write(16'h0092, 16'hB000 + 16'h008F);
        check_bus_writes();
        compare("bus read count", 16'(read_count - first_read), 16'h0002);
        extra_wait = 0;
    endtask

    task automatic test_local_access();
        emit_imm(isa_pkg::OP_MOVI, 3'd1, 8'h80);
        emit_imm(isa_pkg::OP_MOVI, 3'd2, 8'h22);
        emit_imm(isa_pkg::OP_MOVI, 3'd3, 8'hA7);
        emit_reg(isa_pkg::OP_SW, 3'd3, 3'd2, 5'h1E);
        emit_reg(isa_pkg::OP_LW, 3'd4, 3'd2, 5'h1E);
        emit_imm(isa_pkg::OP_MOVI, 3'd5, 8'h40);
        emit_reg(isa_pkg::OP_LW, 3'd6, 3'd5, 5'd0);
        emit_reg(isa_pkg::OP_SW, 3'd4, 3'd1, 5'd0);
        emit_reg(isa_pkg::OP_SW, 3'd6, 3'd1, 5'd1);
        run_program();
        expect_write(16'h0080, 16'h00A7);
        expect_write(16'h0081, 16'(CORE_ID));
        check_bus_writes();
        compare("bus read count", 16'(read_count - first_read), 16'h0000);
    endtask

    // Each store offset marks one path; skipped paths use offsets 1, 4 and 5
    task automatic test_branches();
        emit_imm(isa_pkg::OP_MOVI, 3'd1, 8'h80);
        emit_imm(isa_pkg::OP_MOVI, 3'd2, 8'h05);
        emit_imm(isa_pkg::OP_MOVI, 3'd3, 8'h09);
        emit_reg(isa_pkg::OP_CMP, 3'd2, 3'd2, 5'd0);
        emit_imm(isa_pkg::OP_MOVI, 3'd7, 8'd7);
        emit_imm(isa_pkg::OP_BR, 3'd7, isa_pkg::BR_EQ);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd1);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd2);
        emit_reg(isa_pkg::OP_CMP, 3'd3, 3'd2, 5'd0);
        emit_imm(isa_pkg::OP_MOVI, 3'd7, 8'd12);
        emit_imm(isa_pkg::OP_BR, 3'd7, isa_pkg::BR_EQ);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd3);
        emit_reg(isa_pkg::OP_CMP, 3'd2, 3'd3, 5'd0);
        emit_imm(isa_pkg::OP_MOVI, 3'd7, 8'd16);
        emit_imm(isa_pkg::OP_BR, 3'd7, isa_pkg::BR_LT);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd4);
        emit_imm(isa_pkg::OP_MOVI, 3'd7, 8'd19);
        emit_imm(isa_pkg::OP_BR, 3'd7, isa_pkg::BR_ALWAYS);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd5);
        emit_reg(isa_pkg::OP_SW, 3'd2, 3'd1, 5'd6);
        run_program();
        expect_write(16'h0082, 16'h0005);
        expect_write(16'h0083, 16'h0005);
        expect_write(16'h0086, 16'h0005);
        check_bus_writes();
    endtask

    initial begin
        void'($urandom(13));
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        extra_wait = 0;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = 16'hB000 + 16'(i);
        end
        test_reset_state();
        test_bus_store();
        test_alu_ops();
        test_slow_load();
        test_local_access();
        test_branches();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/micro16_top.sv
/* Multicycle core with one instruction in flight. Program is loaded through the
   prog port while reset is high; the peripheral bus stalls the core on pready */
`timescale 1ns/1ps

module micro16_top #(
    parameter int INSTR_DEPTH = 64,
    parameter int CORE_ID     = 0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_we,
    input  logic [$clog2(INSTR_DEPTH)-1:0] prog_addr,
    input  isa_pkg::instr_t                prog_data,
    input  mem_map_pkg::data_t             prdata,
    input  logic                           pready,
    output logic [$clog2(INSTR_DEPTH)-1:0] pc,
    output logic                           halted,
    output mem_map_pkg::data_t             paddr,
    output logic                           pwrite,
    output logic                           psel,
    output logic                           penable,
    output mem_map_pkg::data_t             pwdata
);

    // Fetch to operand
    logic                issue;
    isa_pkg::instr_t     instr;
    logic                retire;

    // Operand to execute
    logic                op_valid;
    isa_pkg::alu_op_e    alu_op;
    mem_map_pkg::data_t  a;
    mem_map_pkg::data_t  b;
    logic                is_load;
    logic                is_store;
    logic                writes_reg;
    isa_pkg::br_cond_e   br_cond;
    logic                is_branch;
    logic                is_cmp;
    logic [4:0]          mem_offset;

    // Execute to memory and fetch
    logic                ex_valid;
    mem_map_pkg::data_t  result;
    mem_map_pkg::data_t  store_data;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    logic                branch_taken;
    mem_map_pkg::data_t  branch_target;

    // Memory to write-back
    logic                wb_valid;
    mem_map_pkg::data_t  wb_data;
    logic                wb_enable;

    fetch_stage #(.INSTR_DEPTH(INSTR_DEPTH)) u_fetch_stage (.*);

    operand_stage u_operand_stage (.*);

    execute_stage u_execute_stage (.*);

    memory_stage #(.CORE_ID(CORE_ID)) u_memory_stage (.*);

endmodule

//--- hdl/memory_stage.sv
/* Scratch and special register accesses complete in one cycle. Bus accesses
   wait for pready, which may stay low for any number of cycles */
`timescale 1ns/1ps

module memory_stage #(
    parameter int CORE_ID = 0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ex_valid,
    input  mem_map_pkg::data_t result,
    input  mem_map_pkg::data_t store_data,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               reg_write,
    input  mem_map_pkg::data_t prdata,
    input  logic               pready,
    output logic               wb_valid,
    output mem_map_pkg::data_t wb_data,
    output logic               wb_enable,
    output mem_map_pkg::data_t paddr,
    output logic               pwrite,
    output logic               psel,
    output logic               penable,
    output mem_map_pkg::data_t pwdata
);

    localparam int TIM_BITS  = $clog2(mem_map_pkg::TIM_DEPTH);
    localparam int SREG_BITS = $clog2(mem_map_pkg::SREG_COUNT);

    mem_map_pkg::data_t   scratch [mem_map_pkg::TIM_DEPTH];
    logic                 tim_hit;
    logic                 sreg_hit;
    logic                 bus_hit;
    logic                 bus_done;
    logic [TIM_BITS-1:0]  tim_index;
    logic [SREG_BITS-1:0] sreg_index;

    // Address decode
    assign tim_hit    = result >= mem_map_pkg::TIM_BASE && result <= mem_map_pkg::TIM_LAST;
    assign sreg_hit   = result >= mem_map_pkg::SREG_BASE && result <= mem_map_pkg::SREG_LAST;
    assign bus_hit    = (mem_read || mem_write) && !tim_hit && !sreg_hit;
    assign tim_index  = TIM_BITS'(result - mem_map_pkg::TIM_BASE);
    assign sreg_index = SREG_BITS'(result - mem_map_pkg::SREG_BASE);
    assign bus_done   = psel && penable && pready;

    // Bus master and write-back strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid  <= 1'b0;
            wb_enable <= 1'b0;
            psel      <= 1'b0;
            penable   <= 1'b0;
            pwrite    <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            if (ex_valid) begin
                wb_enable <= reg_write;
                if (bus_hit) begin
                    psel   <= 1'b1;
                    pwrite <= mem_write;
                end else begin
                    wb_valid <= 1'b1;
                end
            end else if (psel && !penable) begin
                penable <= 1'b1;
            end else if (bus_done) begin
                psel     <= 1'b0;
                penable  <= 1'b0;
                pwrite   <= 1'b0;
                wb_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            paddr  <= result;
            pwdata <= store_data;
            if (tim_hit && mem_write) begin
                scratch[tim_index] <= store_data;
            end
            if (!mem_read) begin
                wb_data <= result;
            end else if (tim_hit) begin
                wb_data <= scratch[tim_index];
            end else if (sreg_hit) begin
                // Only register 0 is defined, the rest read as zero
                wb_data <= (sreg_index == '0) ? mem_map_pkg::data_t'(CORE_ID) : '0;
            end
        end else if (bus_done) begin
            wb_data <= prdata;
        end
    end

endmodule

//--- hdl/execute_stage.sv
/* ALU, compare flags and branch decision. Loads and stores produce the address
   b plus the signed offset; a branch target is taken from a */
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_valid,
    input  isa_pkg::alu_op_e   alu_op,
    input  mem_map_pkg::data_t a,
    input  mem_map_pkg::data_t b,
    input  logic               is_load,
    input  logic               is_store,
    input  logic               writes_reg,
    input  isa_pkg::br_cond_e  br_cond,
    input  logic               is_branch,
    input  logic               is_cmp,
    input  logic [4:0]         mem_offset,
    output logic               ex_valid,
    output mem_map_pkg::data_t result,
    output mem_map_pkg::data_t store_data,
    output logic               mem_read,
    output logic               mem_write,
    output logic               reg_write,
    output logic               branch_taken,
    output mem_map_pkg::data_t branch_target
);

    logic [isa_pkg::FLAG_WIDTH-1:0] flags;
    mem_map_pkg::data_t             alu_c;
    mem_map_pkg::data_t             addr;
    logic                           cond_met;

    assign addr = b + mem_map_pkg::data_t'($signed(mem_offset));

    always_comb begin
        alu_c = '0;
        case (alu_op)
            isa_pkg::ALU_PASS_B: alu_c = b;
            isa_pkg::ALU_ADD:    alu_c = a + b;
            isa_pkg::ALU_SUB:    alu_c = a - b;
            isa_pkg::ALU_OR:     alu_c = a | b;
            isa_pkg::ALU_XOR:    alu_c = a ^ b;
            isa_pkg::ALU_AND:    alu_c = a & b;
            isa_pkg::ALU_NOT:    alu_c = ~b;
            isa_pkg::ALU_SHL:    alu_c = a << b;
            isa_pkg::ALU_SHR:    alu_c = a >> b;
            isa_pkg::ALU_CMP: begin
                alu_c[isa_pkg::FLAG_Z] = a == b;
                alu_c[isa_pkg::FLAG_L] = a < b;
            end
            default:             alu_c = '0;
        endcase
    end

    // Condition against flags left by the last CMP
    always_comb begin
        case (br_cond)
            isa_pkg::BR_ALWAYS: cond_met = 1'b1;
            isa_pkg::BR_EQ:     cond_met = flags[isa_pkg::FLAG_Z];
            isa_pkg::BR_LT:     cond_met = flags[isa_pkg::FLAG_L];
            default:            cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            reg_write    <= 1'b0;
            branch_taken <= 1'b0;
            flags        <= '0;
        end else begin
            ex_valid <= op_valid;
            if (op_valid) begin
                mem_read     <= is_load;
                mem_write    <= is_store;
                reg_write    <= writes_reg;
                branch_taken <= is_branch && cond_met;
                if (is_cmp) begin
                    flags <= alu_c[isa_pkg::FLAG_WIDTH-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            result        <= (is_load || is_store) ? addr : alu_c;
            store_data    <= a;
            branch_target <= a;
        end
    end

endmodule

//--- hdl/operand_stage.sv
/* Decode and eight-entry register file. R[rd] is read in the issue cycle and the
   second operand one cycle later; write-back retires the instruction */
`timescale 1ns/1ps

module operand_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  isa_pkg::instr_t    instr,
    input  logic               wb_valid,
    input  logic               wb_enable,
    input  mem_map_pkg::data_t wb_data,
    output logic               op_valid,
    output isa_pkg::alu_op_e   alu_op,
    output mem_map_pkg::data_t a,
    output mem_map_pkg::data_t b,
    output logic               is_load,
    output logic               is_store,
    output logic               writes_reg,
    output isa_pkg::br_cond_e  br_cond,
    output logic               is_branch,
    output logic               is_cmp,
    output logic [4:0]         mem_offset,
    output logic               retire
);

    isa_pkg::opcode_e   opcode;
    logic [4:0]         simm5;
    logic               add_imm;
    logic               read_b;
    logic [2:0]         wb_rd;
    mem_map_pkg::data_t regs [8];

    assign opcode     = instr.r.opcode;
    assign simm5      = instr.r.simm5;
    assign add_imm    = opcode == isa_pkg::OP_ARITH && !simm5[4];
    assign is_load    = opcode == isa_pkg::OP_LW;
    assign is_store   = opcode == isa_pkg::OP_SW;
    assign is_branch  = opcode == isa_pkg::OP_BR;
    assign is_cmp     = opcode == isa_pkg::OP_CMP;
    assign writes_reg = opcode inside {isa_pkg::OP_LW, isa_pkg::OP_MOV, isa_pkg::OP_MOVI,
                                       isa_pkg::OP_ARITH, isa_pkg::OP_BIT};
    assign br_cond    = isa_pkg::br_cond_e'(instr.i.imm8);
    assign mem_offset = simm5;
    assign retire     = wb_valid;

    always_comb begin
        alu_op = isa_pkg::ALU_ZERO;
        case (opcode)
            isa_pkg::OP_LW, isa_pkg::OP_SW,
            isa_pkg::OP_MOV, isa_pkg::OP_MOVI: alu_op = isa_pkg::ALU_PASS_B;
            isa_pkg::OP_CMP:                   alu_op = isa_pkg::ALU_CMP;
            isa_pkg::OP_ARITH: begin
                if (add_imm || simm5 == isa_pkg::ARITH_ADD) begin
                    alu_op = isa_pkg::ALU_ADD;
                end else if (simm5 == isa_pkg::ARITH_SUB) begin
                    alu_op = isa_pkg::ALU_SUB;
                end
            end
            isa_pkg::OP_BIT: begin
                case (simm5)
                    isa_pkg::BIT_OR:  alu_op = isa_pkg::ALU_OR;
                    isa_pkg::BIT_XOR: alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::BIT_AND: alu_op = isa_pkg::ALU_AND;
                    isa_pkg::BIT_NOT: alu_op = isa_pkg::ALU_NOT;
                    isa_pkg::BIT_SHL: alu_op = isa_pkg::ALU_SHL;
                    isa_pkg::BIT_SHR: alu_op = isa_pkg::ALU_SHR;
                    default:          alu_op = isa_pkg::ALU_ZERO;
                endcase
            end
            default: alu_op = isa_pkg::ALU_ZERO;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_enable) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_b   <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            read_b   <= issue;
            op_valid <= read_b;
        end
    end

    // Operand capture over two cycles
    always_ff @(posedge clk) begin
        if (issue) begin
            a     <= regs[instr.r.rd];
            wb_rd <= instr.r.rd;
        end
        if (read_b) begin
            if (opcode == isa_pkg::OP_MOVI || opcode == isa_pkg::OP_BR) begin
                b <= mem_map_pkg::data_t'(instr.i.imm8);
            end else if (add_imm) begin
                b <= regs[instr.r.ra] + mem_map_pkg::data_t'(simm5[3:0]);
            end else begin
                b <= regs[instr.r.ra];
            end
        end
    end

endmodule

//--- hdl/fetch_stage.sv
/* INSTR_DEPTH must be a power of two. Program words load only during reset, and
   a fetched HALT stops issue until the next reset */
`timescale 1ns/1ps

module fetch_stage #(
    parameter int INSTR_DEPTH = 64
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_we,
    input  logic [$clog2(INSTR_DEPTH)-1:0] prog_addr,
    input  isa_pkg::instr_t                prog_data,
    input  logic                           retire,
    input  logic                           branch_taken,
    input  mem_map_pkg::data_t             branch_target,
    output logic                           issue,
    output isa_pkg::instr_t                instr,
    output logic [$clog2(INSTR_DEPTH)-1:0] pc,
    output logic                           halted
);

    localparam int ADDR_BITS = $clog2(INSTR_DEPTH);

    isa_pkg::instr_t imem [INSTR_DEPTH];
    isa_pkg::instr_t fetched;
    logic            read_en;
    logic            is_halt;

    assign fetched = imem[pc];
    assign is_halt = fetched.r.opcode == isa_pkg::OP_HALT;

    // Load port, open only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en) begin
            instr <= fetched;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_en <= 1'b1;
            issue   <= 1'b0;
            halted  <= 1'b0;
            pc      <= '0;
        end else begin
            // Read one cycle, issue the next
            issue   <= read_en && !is_halt;
            read_en <= retire;
            if (read_en && is_halt) begin
                halted <= 1'b1;
            end
            if (retire) begin
                if (branch_taken) begin
                    pc <= branch_target[ADDR_BITS-1:0];
                end else if (pc != ADDR_BITS'(INSTR_DEPTH - 1)) begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/mem_map_pkg.sv
/* Data word and data address map. Addresses outside the scratch and special
   register ranges go to the peripheral bus */
package mem_map_pkg;

    localparam int DATA_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Local scratch memory
    localparam data_t TIM_BASE = 16'h0000;
    localparam data_t TIM_LAST = 16'h003F;

    // Read-only special registers, register 0 holds the core number
    localparam data_t SREG_BASE = 16'h0040;
    localparam data_t SREG_LAST = 16'h0047;

    localparam int TIM_DEPTH  = int'(TIM_LAST - TIM_BASE) + 1;
    localparam int SREG_COUNT = int'(SREG_LAST - SREG_BASE) + 1;

endpackage

//--- hdl/isa_pkg.sv
/* Instruction set of the 16-bit core. Opcodes that are not listed execute as NOP,
   and branch conditions that are not listed never branch */
package isa_pkg;

    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_LW    = 5'd1,
        OP_SW    = 5'd2,
        OP_MOV   = 5'd3,
        OP_MOVI  = 5'd4,
        OP_ARITH = 5'd5,
        OP_BIT   = 5'd6,
        OP_CMP   = 5'd7,
        OP_BR    = 5'd8,
        OP_HALT  = 5'd9
    } opcode_e;

    // Register view, used by everything except MOVI and BR
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [2:0] ra;
        logic [4:0] simm5;
    } instr_reg_t;

    // Immediate view for MOVI and BR
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [7:0] imm8;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_OR, ALU_XOR, ALU_AND,
        ALU_NOT, ALU_SHL, ALU_SHR, ALU_CMP, ALU_ZERO
    } alu_op_e;

    // ARITH sub-ops in simm5; bit 4 clear means add-immediate
    localparam logic [4:0] ARITH_ADD = 5'd16;
    localparam logic [4:0] ARITH_SUB = 5'd17;

    // BIT sub-ops in simm5
    localparam logic [4:0] BIT_OR  = 5'd0;
    localparam logic [4:0] BIT_XOR = 5'd1;
    localparam logic [4:0] BIT_AND = 5'd2;
    localparam logic [4:0] BIT_NOT = 5'd3;
    localparam logic [4:0] BIT_SHL = 5'd4;
    localparam logic [4:0] BIT_SHR = 5'd5;

    // Branch condition, carried in imm8 of BR
    typedef enum logic [7:0] {
        BR_ALWAYS = 8'd0,
        BR_EQ     = 8'd1,
        BR_LT     = 8'd2
    } br_cond_e;

    // Compare flag word
    localparam int FLAG_WIDTH = 3;
    localparam int FLAG_Z     = 1;
    localparam int FLAG_L     = 2;

endpackage
